// ==== logic/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int data_width = 16;

    // opcode order and codes follow the microcode ALUOp encoding
    typedef enum logic [4:0] {
        alu_op_sela       = 5'd0,
        alu_op_selb       = 5'd1,
        alu_op_add        = 5'd2,
        alu_op_adc        = 5'd3,
        alu_op_and        = 5'd4,
        alu_op_xor        = 5'd5,
        alu_op_or         = 5'd6,
        alu_op_sub        = 5'd7,
        alu_op_subrev     = 5'd8,
        alu_op_sbb        = 5'd9,
        alu_op_sbbrev     = 5'd10,
        alu_op_getflags   = 5'd11,
        alu_op_setflags_a = 5'd12,
        alu_op_setflags_b = 5'd13,
        alu_op_cmc        = 5'd14,
        alu_op_shr        = 5'd15,
        alu_op_shl        = 5'd16,
        alu_op_sar        = 5'd17,
        alu_op_ror        = 5'd18,
        alu_op_rol        = 5'd19,
        alu_op_rcl        = 5'd20,
        alu_op_rcr        = 5'd21
    } alu_op_t;  // codes 22 to 31 are not assigned

    // bit positions inside the FLAGS word
    localparam int cf_idx = 0;
    localparam int pf_idx = 2;
    localparam int af_idx = 4;
    localparam int zf_idx = 6;
    localparam int sf_idx = 7;
    localparam int of_idx = 11;

    // bit 1 is reserved and always reads as one
    localparam logic [data_width-1:0] flags_reset = 16'h0002;

    typedef struct packed {
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        alu_op_t               op;
        logic                  is_8_bit;
        logic                  write_flags;  // commit this request's flags to FLAGS
    } alu_req_t;

endpackage

`default_nettype wire

// ==== logic/shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module shifter (
    input  logic [exec_pkg::data_width-1:0] a,
    input  logic [4:0]                      count,
    input  exec_pkg::alu_op_t               op,
    input  logic                            is_8_bit,
    input  logic [exec_pkg::data_width-1:0] flags_in,
    output logic [exec_pkg::data_width-1:0] result,
    output logic [exec_pkg::data_width-1:0] flags
);
    import exec_pkg::*;

    logic [data_width-1:0] a_low;  // operand with the upper byte cleared in 8-bit mode
    logic                  a_top;
    logic                  a_next;
    logic [data_width:0]   shr_full;
    logic [data_width:0]   shl_wide;
    logic [8:0]            shl_narrow;
    logic signed [16:0]    sar_wide;
    logic signed [8:0]     sar_narrow;
    logic [data_width-1:0] rot_val;
    logic                  rot_cf;
    logic                  sh_cf;
    logic                  sh_of;

    // one rotate step, returns the new carry above the new value
    function automatic logic [16:0] rotate_step(input alu_op_t step_op, input logic narrow,
                                                input logic c, input logic [15:0] v);
        logic        top;
        logic        next_c;
        logic [15:0] next;
        top    = narrow ? v[7] : v[15];
        next   = v;
        next_c = c;
        case (step_op)
            alu_op_rol: begin
                next_c = top;
                next   = narrow ? {8'h00, v[6:0], top} : {v[14:0], top};
            end
            alu_op_ror: begin
                next_c = v[0];
                next   = narrow ? {8'h00, v[0], v[7:1]} : {v[0], v[15:1]};
            end
            alu_op_rcl: begin
                next_c = top;
                next   = narrow ? {8'h00, v[6:0], c} : {v[14:0], c};  // carry enters at bit 0
            end
            alu_op_rcr: begin
                next_c = v[0];
                next   = narrow ? {8'h00, c, v[7:1]} : {c, v[15:1]};
            end
            default: ;
        endcase
        return {next_c, next};
    endfunction

    assign a_low  = is_8_bit ? {8'h00, a[7:0]} : a;
    assign a_top  = is_8_bit ? a[7] : a[15];
    assign a_next = is_8_bit ? a[6] : a[14];

    // an extra bit below or above the operand catches the last bit shifted out
    assign shr_full   = {a_low, 1'b0} >> count;
    assign shl_wide   = {1'b0, a} << count;
    assign shl_narrow = {1'b0, a[7:0]} << count;
    assign sar_wide   = $signed({a, 1'b0}) >>> count;
    assign sar_narrow = $signed({a[7:0], 1'b0}) >>> count;

    always_comb begin
        rot_val = a_low;
        rot_cf  = flags_in[cf_idx];
        for (int i = 0; i < 31; i++) begin
            if (i < int'(count))
                {rot_cf, rot_val} = rotate_step(op, is_8_bit, rot_cf, rot_val);
        end
    end

    always_comb begin
        result = a_low;
        sh_cf  = flags_in[cf_idx];
        sh_of  = flags_in[of_idx];
        case (op)
            alu_op_shr: begin
                result = shr_full[16:1];
                sh_cf  = shr_full[0];
                sh_of  = a_top;  // original sign bit
            end
            alu_op_shl: begin
                if (is_8_bit) begin
                    result = {a[15:8], shl_narrow[7:0]};
                    sh_cf  = shl_narrow[8];
                end else begin
                    result = shl_wide[15:0];
                    sh_cf  = shl_wide[16];
                end
                sh_of = a_top ^ (is_8_bit ? result[7] : result[15]);
            end
            alu_op_sar: begin
                result = is_8_bit ? {8'h00, sar_narrow[8:1]} : sar_wide[16:1];
                sh_cf  = is_8_bit ? sar_narrow[0] : sar_wide[0];
                sh_of  = 1'b0;
            end
            alu_op_ror: begin
                result = rot_val;
                sh_cf  = rot_cf;
                sh_of  = a_top ^ a[0];
            end
            alu_op_rol, alu_op_rcl: begin
                result = rot_val;
                sh_cf  = rot_cf;
                sh_of  = a_top ^ a_next;
            end
            alu_op_rcr: begin
                result = rot_val;
                sh_cf  = rot_cf;
                sh_of  = a_top ^ flags_in[cf_idx];
            end
            default: ;
        endcase
    end

    always_comb begin
        flags = flags_in;  // a zero count keeps every flag
        if (count != 5'd0) begin
            flags[cf_idx] = sh_cf;
            flags[of_idx] = sh_of;
            flags[pf_idx] = ~^result[7:0];
            flags[sf_idx] = is_8_bit ? result[7] : result[15];
            flags[zf_idx] = is_8_bit ? ~|result[7:0] : ~|result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  exec_pkg::alu_req_t              req,
    input  logic [exec_pkg::data_width-1:0] flags_in,
    output logic [exec_pkg::data_width-1:0] result,
    output logic [exec_pkg::data_width-1:0] flags_out
);
    import exec_pkg::*;

    logic                  is_rev;
    logic                  is_sub;
    logic                  use_carry;
    logic                  cin;
    logic [data_width-1:0] op_x;
    logic [data_width-1:0] op_y;
    logic [data_width:0]   sum;
    logic [data_width:0]   diff;
    logic [data_width:0]   ar_full;
    logic [data_width-1:0] ar_res;
    logic                  ar_cf;
    logic                  ar_of;
    logic                  x_top;
    logic                  y_top;
    logic                  r_top;
    logic [data_width-1:0] lg_res;
    logic [data_width-1:0] sh_result;
    logic [data_width-1:0] sh_flags;

    // parity, auxiliary carry, sign and zero from a result
    function automatic logic [15:0] status_flags(input logic [15:0] f, input logic [15:0] r,
                                                 input logic [15:0] x, input logic [15:0] y,
                                                 input logic narrow);
        logic [15:0] n;
        n         = f;
        n[pf_idx] = ~^r[7:0];  // parity looks at the low byte only
        n[af_idx] = x[4] ^ y[4] ^ r[4];
        n[sf_idx] = narrow ? r[7] : r[15];
        n[zf_idx] = narrow ? ~|r[7:0] : ~|r;
        return n;
    endfunction

    shifter i_shifter (
        .a        (req.a),
        .count    (req.b[4:0]),
        .op       (req.op),
        .is_8_bit (req.is_8_bit),
        .flags_in (flags_in),
        .result   (sh_result),
        .flags    (sh_flags)
    );

    assign is_rev    = req.op inside {alu_op_subrev, alu_op_sbbrev};
    assign is_sub    = req.op inside {alu_op_sub, alu_op_subrev, alu_op_sbb, alu_op_sbbrev};
    assign use_carry = req.op inside {alu_op_adc, alu_op_sbb, alu_op_sbbrev};

    // reversed subtracts compute b - a
    assign op_x = is_rev ? req.b : req.a;
    assign op_y = is_rev ? req.a : req.b;
    assign cin  = use_carry & flags_in[cf_idx];

    assign sum     = {1'b0, op_x} + {1'b0, op_y} + {16'h0000, cin};
    assign diff    = {1'b0, op_x} - {1'b0, op_y} - {16'h0000, cin};
    assign ar_full = is_sub ? diff : sum;
    assign ar_res  = ar_full[15:0];

    assign x_top = req.is_8_bit ? op_x[7] : op_x[15];
    assign y_top = req.is_8_bit ? op_y[7] : op_y[15];
    assign r_top = req.is_8_bit ? ar_res[7] : ar_res[15];

    // in byte mode the carry (or borrow) into bit 8 is recovered from the full sum
    assign ar_cf = req.is_8_bit ? (op_x[8] ^ op_y[8] ^ ar_res[8]) : ar_full[16];
    assign ar_of = is_sub ? ((x_top ^ y_top) & (r_top ^ x_top))
                          : (~(x_top ^ y_top) & (r_top ^ y_top));

    always_comb begin
        case (req.op)
            alu_op_and: lg_res = req.a & req.b;
            alu_op_xor: lg_res = req.a ^ req.b;
            default:    lg_res = req.a | req.b;
        endcase
    end

    always_comb begin
        result    = req.a;     // also what unused opcodes return
        flags_out = flags_in;  // flags an opcode does not define pass through
        case (req.op)
            alu_op_sela: result = req.a;
            alu_op_selb: result = req.b;
            alu_op_add, alu_op_adc, alu_op_sub, alu_op_subrev, alu_op_sbb,
            alu_op_sbbrev: begin
                result            = ar_res;
                flags_out         = status_flags(flags_in, ar_res, op_x, op_y, req.is_8_bit);
                flags_out[cf_idx] = ar_cf;
                flags_out[of_idx] = ar_of;
            end
            alu_op_and, alu_op_xor, alu_op_or: begin
                result            = lg_res;
                flags_out         = status_flags(flags_in, lg_res, req.a, req.b, req.is_8_bit);
                flags_out[cf_idx] = 1'b0;
                flags_out[of_idx] = 1'b0;
            end
            alu_op_getflags:   result = flags_in;
            alu_op_setflags_a: flags_out = req.a;
            alu_op_setflags_b: flags_out = req.b;
            alu_op_cmc:        flags_out[cf_idx] = ~flags_in[cf_idx];
            alu_op_shr, alu_op_shl, alu_op_sar, alu_op_ror, alu_op_rol, alu_op_rcl,
            alu_op_rcr: begin
                result    = sh_result;
                flags_out = sh_flags;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/flags_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module flags_reg (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            write,
    input  logic [exec_pkg::data_width-1:0] flags_next,
    output logic [exec_pkg::data_width-1:0] flags
);
    import exec_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= flags_reset;
        end else if (write) begin
            // flags_reset is exactly the reserved bit, which stays set on every load
            flags <= flags_next | flags_reset;
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            req_valid,
    input  exec_pkg::alu_req_t              req,
    output logic [exec_pkg::data_width-1:0] result,
    output logic                            result_valid,
    output logic [exec_pkg::data_width-1:0] flags
);
    import exec_pkg::*;

    logic [data_width-1:0] alu_result;
    logic [data_width-1:0] alu_flags;
    logic                  flags_write;

    // the ALU sees the committed FLAGS, so a request right behind a writer gets its carry
    alu i_alu (
        .req       (req),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    assign flags_write = req_valid & req.write_flags;

    flags_reg i_flags_reg (
        .clk        (clk),
        .reset      (reset),
        .write      (flags_write),
        .flags_next (alu_flags),
        .flags      (flags)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= req_valid;  // one pulse per request
            if (req_valid)
                result <= alu_result;   // held while no request arrives
        end
    end

endmodule

`default_nettype wire

// ==== tests/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// parity of the low byte, sign and zero for the width, and the nibble carry
function automatic logic [15:0] model_status(input logic [15:0] f, input logic [15:0] r,
                                             input logic [15:0] x, input logic [15:0] y,
                                             input logic narrow);
    logic [15:0] n;
    n         = f;
    n[pf_idx] = ~^r[7:0];
    n[af_idx] = x[4] ^ y[4] ^ r[4];
    n[sf_idx] = narrow ? r[7] : r[15];
    n[zf_idx] = narrow ? (r[7:0] == 8'h00) : (r == 16'h0000);
    return n;
endfunction

// returns the expected result in the upper half and the expected flags in the lower half
function automatic logic [31:0] model_alu(input alu_req_t r, input logic [15:0] f);
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] res;
    logic [15:0] nf;
    logic [15:0] v;
    logic [16:0] wide;
    logic [8:0]  low_sum;
    logic        cy;
    logic        c;
    logic        top;
    logic        bit0;
    logic        narrow;
    logic        a_top;
    int          n;
    narrow = r.is_8_bit;
    res    = r.a;
    nf     = f;
    n      = int'(r.b[4:0]);
    a_top  = narrow ? r.a[7] : r.a[15];
    case (r.op)
        alu_op_selb: res = r.b;
        alu_op_add, alu_op_adc: begin
            cy      = (r.op == alu_op_adc) ? f[cf_idx] : 1'b0;
            wide    = {1'b0, r.a} + {1'b0, r.b} + {16'h0000, cy};
            low_sum = {1'b0, r.a[7:0]} + {1'b0, r.b[7:0]} + {8'h00, cy};
            res     = wide[15:0];
            nf      = model_status(f, res, r.a, r.b, narrow);
            nf[cf_idx] = narrow ? low_sum[8] : wide[16];
            nf[of_idx] = narrow ? (r.a[7] == r.b[7]) && (res[7] != r.a[7])
                                : (r.a[15] == r.b[15]) && (res[15] != r.a[15]);
        end
        alu_op_sub, alu_op_subrev, alu_op_sbb, alu_op_sbbrev: begin
            x  = (r.op inside {alu_op_subrev, alu_op_sbbrev}) ? r.b : r.a;
            y  = (r.op inside {alu_op_subrev, alu_op_sbbrev}) ? r.a : r.b;
            cy = (r.op inside {alu_op_sbb, alu_op_sbbrev}) ? f[cf_idx] : 1'b0;
            wide    = {1'b0, x} - {1'b0, y} - {16'h0000, cy};
            low_sum = {1'b0, x[7:0]} - {1'b0, y[7:0]} - {8'h00, cy};
            res     = wide[15:0];
            nf      = model_status(f, res, x, y, narrow);
            nf[cf_idx] = narrow ? low_sum[8] : wide[16];  // borrow out of the width
            nf[of_idx] = narrow ? (x[7] != y[7]) && (res[7] != x[7])
                                : (x[15] != y[15]) && (res[15] != x[15]);
        end
        alu_op_and, alu_op_or, alu_op_xor: begin
            if (r.op == alu_op_and)
                res = r.a & r.b;
            else if (r.op == alu_op_or)
                res = r.a | r.b;
            else
                res = r.a ^ r.b;
            nf         = model_status(f, res, r.a, r.b, narrow);
            nf[cf_idx] = 1'b0;
            nf[of_idx] = 1'b0;
        end
        alu_op_getflags:   res = f;
        alu_op_setflags_a: nf = r.a;
        alu_op_setflags_b: nf = r.b;
        alu_op_cmc:        nf[cf_idx] = ~f[cf_idx];
        alu_op_shr, alu_op_shl, alu_op_sar, alu_op_ror, alu_op_rol, alu_op_rcl,
        alu_op_rcr: begin
            v = narrow ? {8'h00, r.a[7:0]} : r.a;
            c = f[cf_idx];
            // walk one bit position at a time, c ends as the last bit out
            for (int i = 0; i < n; i++) begin
                top  = narrow ? v[7] : v[15];
                bit0 = v[0];
                case (r.op)
                    alu_op_shr: begin
                        c = bit0;
                        v = v >> 1;
                    end
                    alu_op_shl: begin
                        c = top;
                        v = narrow ? {8'h00, v[6:0], 1'b0} : {v[14:0], 1'b0};
                    end
                    alu_op_sar: begin
                        c = bit0;
                        v = narrow ? {8'h00, v[7], v[7:1]} : {v[15], v[15:1]};
                    end
                    alu_op_rol: begin
                        c = top;
                        v = narrow ? {8'h00, v[6:0], top} : {v[14:0], top};
                    end
                    alu_op_ror: begin
                        c = bit0;
                        v = narrow ? {8'h00, bit0, v[7:1]} : {bit0, v[15:1]};
                    end
                    alu_op_rcl: begin
                        v = narrow ? {8'h00, v[6:0], c} : {v[14:0], c};
                        c = top;
                    end
                    default: begin
                        v = narrow ? {8'h00, c, v[7:1]} : {c, v[15:1]};
                        c = bit0;
                    end
                endcase
            end
            res = (r.op == alu_op_shl && narrow) ? {r.a[15:8], v[7:0]} : v;
            if (n != 0) begin
                nf[cf_idx] = c;
                case (r.op)
                    alu_op_shr: nf[of_idx] = a_top;
                    alu_op_shl: nf[of_idx] = a_top ^ (narrow ? res[7] : res[15]);
                    alu_op_sar: nf[of_idx] = 1'b0;
                    alu_op_ror: nf[of_idx] = a_top ^ r.a[0];
                    alu_op_rcr: nf[of_idx] = a_top ^ f[cf_idx];
                    default:    nf[of_idx] = a_top ^ (narrow ? r.a[6] : r.a[14]);
                endcase
                nf[pf_idx] = ~^res[7:0];
                nf[sf_idx] = narrow ? res[7] : res[15];
                nf[zf_idx] = narrow ? (res[7:0] == 8'h00) : (res == 16'h0000);
            end
        end
        default: res = r.a;
    endcase
    return {res, nf};
endfunction

`endif

// ==== tests/tb_exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exec_unit;
    import exec_pkg::*;

    `include "alu_model.svh"

    localparam int total_requests = 629;
    localparam int clk_period = 4;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  req_valid;
    alu_req_t              req;
    logic [data_width-1:0] result;
    logic                  result_valid;
    logic [data_width-1:0] flags;

    logic [15:0]  flags_mirror;
    logic [31:0]  lcg_state;
    int           cycle;
    int           value_errors;
    int           other_errors;
    logic [15:0]  exp_result[$];
    logic [15:0]  exp_flags[$];
    int           exp_cycle[$];
    string        exp_name[$];

    exec_unit i_exec_unit (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .result       (result),
        .result_valid (result_valid),
        .flags        (flags)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // queue the expected response, then present the request until the next edge
    task automatic send_req(input logic [15:0] a, input logic [15:0] b, input alu_op_t op,
                            input logic is8, input logic wf, input string name);
        alu_req_t    r;
        logic [31:0] exp;
        r.a           = a;
        r.b           = b;
        r.op          = op;
        r.is_8_bit    = is8;
        r.write_flags = wf;
        exp = model_alu(r, flags_mirror);
        if (wf)
            flags_mirror = exp[15:0] | 16'h0002;
        exp_result.push_back(exp[31:16]);
        exp_flags.push_back(flags_mirror);
        exp_cycle.push_back(cycle + 1);
        exp_name.push_back(name);
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle();
        req_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin : compare
        logic [15:0] er;
        logic [15:0] ef;
        int          ec;
        string       nm;
        if (reset) begin
            assert (!result_valid) else begin
                other_errors++;
                $display("result_valid was high while reset was asserted");
            end
        end else if (result_valid) begin
            assert (exp_result.size() != 0) else begin
                other_errors++;
                $display("result_valid pulsed with no request outstanding");
            end
            if (exp_result.size() != 0) begin
                er = exp_result.pop_front();
                ef = exp_flags.pop_front();
                ec = exp_cycle.pop_front();
                nm = exp_name.pop_front();
                assert (result == er) else begin
                    value_errors++;
                    $display("[ERROR] %s result expected %h actual %h", nm, er, result);
                end
                assert (flags == ef) else begin
                    value_errors++;
                    $display("[ERROR] %s flags expected %h actual %h", nm, ef, flags);
                end
                assert (cycle == ec) else begin
                    value_errors++;
                    $display("[ERROR] %s cycle expected %0d actual %0d", nm, ec, cycle);
                end
            end
        end
    end

    initial begin : watchdog
        #((total_requests + 64) * clk_period * 2);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        logic [15:0] pa[8];
        logic [15:0] pb[8];
        int          counts[7];
        alu_op_t     op;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        pa = '{16'h007f, 16'h00ff, 16'h0080, 16'h7fff, 16'hffff, 16'h8000, 16'h0000, 16'h0000};
        pb = '{16'h0001, 16'h0001, 16'h0080, 16'h0001, 16'hffff, 16'h0001, 16'h0000, 16'h0001};
        counts = '{0, 1, 7, 8, 15, 16, 31};
        req_valid    = 1'b0;
        req          = '0;
        reset        = 1'b1;
        cycle        = 0;
        value_errors = 0;
        other_errors = 0;
        lcg_state    = 32'd47750;
        flags_mirror = 16'h0002;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (flags == 16'h0002) else begin
            value_errors++;
            $display("[ERROR] reset flags expected %h actual %h", 16'h0002, flags);
        end
        assert (result == 16'h0000) else begin
            value_errors++;
            $display("[ERROR] reset result expected %h actual %h", 16'h0000, result);
        end

        // arithmetic corners, carry from one request feeds the next adc or sbb
        for (int o = int'(alu_op_add); o <= int'(alu_op_sbbrev); o++) begin
            op = alu_op_t'(o);
            if (op inside {alu_op_and, alu_op_xor, alu_op_or})
                continue;
            for (int w = 0; w < 2; w++)
                for (int p = 0; p < 8; p++)
                    send_req(pa[p], pb[p], op, w[0], 1'b1, $sformatf("%s_w%0d", op.name(), w));
        end

        // carry and overflow are set first so each logic op has to clear them
        for (int w = 0; w < 2; w++) begin
            send_req(16'h0000, 16'h0801, alu_op_setflags_b, 1'b0, 1'b1, "set_cf_of");
            send_req(16'hf0f0, 16'h0ff0, alu_op_and, w[0], 1'b1, "and");
            send_req(16'h0000, 16'h0801, alu_op_setflags_b, 1'b0, 1'b1, "set_cf_of");
            send_req(16'h8080, 16'h0101, alu_op_or, w[0], 1'b1, "or");
            send_req(16'h0000, 16'h0801, alu_op_setflags_b, 1'b0, 1'b1, "set_cf_of");
            send_req(16'h5a5a, 16'h5a5a, alu_op_xor, w[0], 1'b1, "xor");
        end
        send_req(16'hfffd, 16'h0000, alu_op_setflags_a, 1'b0, 1'b1, "setflags_a");
        send_req(16'h0000, 16'h0000, alu_op_getflags, 1'b0, 1'b0, "getflags");
        send_req(16'h0000, 16'h0000, alu_op_setflags_b, 1'b0, 1'b1, "setflags_b");
        send_req(16'h0000, 16'h0000, alu_op_cmc, 1'b0, 1'b1, "cmc");
        send_req(16'h0000, 16'h0000, alu_op_getflags, 1'b0, 1'b0, "getflags");
        send_req(16'h0000, 16'h0000, alu_op_cmc, 1'b0, 1'b1, "cmc");
        idle_cycle();

        for (int o = int'(alu_op_shr); o <= int'(alu_op_rcr); o++) begin
            op = alu_op_t'(o);
            for (int w = 0; w < 2; w++)
                for (int k = 0; k < 7; k++)
                    send_req((k % 2 == 0) ? 16'h81c3 : 16'h3c5a, counts[k][15:0], op, w[0],
                             1'b1, $sformatf("%s_w%0d_c%0d", op.name(), w, counts[k]));
        end

        // chains that live on the carry of the request just before
        send_req(16'h0000, 16'h0001, alu_op_setflags_b, 1'b0, 1'b1, "chain_set");
        for (int i = 0; i < 4; i++)
            send_req(16'hffff, 16'h0000, alu_op_adc, 1'b0, 1'b1, "chain_adc");
        for (int i = 0; i < 6; i++)
            send_req(16'h8001 ^ i[15:0], 16'h0001, alu_op_rcl, i[0], 1'b1, "chain_rcl");
        for (int i = 0; i < 6; i++)
            send_req(16'h4003 ^ i[15:0], 16'h0001, alu_op_rcr, i[0], 1'b1, "chain_rcr");
        idle_cycle();

        for (int i = 0; i < 400; i++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            r3 = lcg_next();
            send_req(r1[31:16], r2[31:16], alu_op_t'(r3[20:16]), r3[21], r3[22], "random");
            if (r3[23] & r3[24])
                idle_cycle();
        end

        idle_cycle();
        repeat (3) @(posedge clk);
        #1;
        assert (exp_result.size() == 0) else begin
            other_errors++;
            $display("%0d expected results never came out of the DUT", exp_result.size());
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+tests
logic/exec_pkg.sv
logic/shifter.sv
logic/alu.sv
logic/flags_reg.sv
logic/exec_unit.sv
tests/tb_exec_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the exec_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_exec_unit -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_exec_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^sim passed$"; then
    exit 0
fi
exit 1
